/* source/gpu_geom_pkg.sv */
package gpu_geom_pkg;

  // Screen coordinate widths, enough for 640 x 480
  localparam int COORD_X_W = 10;
  localparam int COORD_Y_W = 9;

  localparam int CHANNEL_W = 8;

  // Horizontal pixel position
  typedef logic [COORD_X_W-1:0] coord_x_t;

  // Vertical pixel position
  typedef logic [COORD_Y_W-1:0] coord_y_t;

  // One colour channel
  typedef logic [CHANNEL_W-1:0] channel_t;

  // Red in the top byte, then green, blue at the bottom
  typedef logic [3*$bits(channel_t)-1:0] color_t;

endpackage

/* source/gpu_cmd_pkg.sv */
package gpu_cmd_pkg;

  localparam int WB_DATA_W = 32;
  localparam int WB_ADDR_W = 3;
  localparam int OPCODE_W  = 4;

  typedef logic [WB_DATA_W-1:0] wb_data_t;
  typedef logic [WB_ADDR_W-1:0] wb_addr_t;

  // Instruction opcode, low nibble of the command word
  typedef logic [OPCODE_W-1:0] opcode_t;

  localparam opcode_t OP_NOP   = 4'd0;
  localparam opcode_t OP_POINT = 4'd1;
  localparam opcode_t OP_HLINE = 4'd2;
  localparam opcode_t OP_RECT  = 4'd3;
  localparam opcode_t OP_CLEAR = 4'd4;

  // Wishbone word offsets
  localparam wb_addr_t REG_X1     = 3'd0;
  localparam wb_addr_t REG_Y1     = 3'd1;
  localparam wb_addr_t REG_X2     = 3'd2;
  localparam wb_addr_t REG_Y2     = 3'd3;
  localparam wb_addr_t REG_COLOR  = 3'd4;
  localparam wb_addr_t REG_CMD    = 3'd5; // Write pushes an instruction
  localparam wb_addr_t REG_STATUS = 3'd6; // Read only

  // Status word bit positions
  localparam int STAT_EMPTY_BIT = 0;
  localparam int STAT_FULL_BIT  = 1;
  localparam int STAT_BUSY_BIT  = 2;

endpackage

/* source/gpu_instr_if.sv */
`timescale 1ns/1ps

interface gpu_instr_if
  import gpu_geom_pkg::*, gpu_cmd_pkg::*;
  ();

  // Write side, filled by the command decoder
  opcode_t  w_opcode;
  coord_x_t w_x1;
  coord_y_t w_y1;
  coord_x_t w_x2;
  coord_y_t w_y2;
  color_t   w_color;
  logic     push;
  logic     full;

  // Read side, always the oldest entry
  opcode_t  r_opcode;
  coord_x_t r_x1;
  coord_y_t r_y1;
  coord_x_t r_x2;
  coord_y_t r_y2;
  color_t   r_color;
  logic     pop;
  logic     empty;

  // Decoder also reports empty in its status word
  modport producer (
    output w_opcode, w_x1, w_y1, w_x2, w_y2, w_color, push,
    input  full, empty
  );

  modport buffer (
    input  w_opcode, w_x1, w_y1, w_x2, w_y2, w_color, push, pop,
    output r_opcode, r_x1, r_y1, r_x2, r_y2, r_color, empty, full
  );

  modport consumer (
    input  r_opcode, r_x1, r_y1, r_x2, r_y2, r_color, empty,
    output pop
  );

endinterface

/* source/gpu_wb_cmd_decoder.sv */
`timescale 1ns/1ps

module gpu_wb_cmd_decoder
  import gpu_geom_pkg::*, gpu_cmd_pkg::*;
  (
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  wb_addr_t             wb_adr_i,
  input  wb_data_t             wb_dat_i,
  output wb_data_t             wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 engine_busy_i,
  gpu_instr_if.producer        instr
  );

  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WAIT_RELEASE
  } state_t;

  state_t state, next_state;

  // Shadow copies of the shape parameters
  coord_x_t x1_q;
  coord_y_t y1_q;
  coord_x_t x2_q;
  coord_y_t y2_q;
  color_t   color_q;

  logic     wb_req;
  logic     cmd_stall;
  logic     wr_en;
  wb_data_t status_word;

  assign wb_req = wb_cyc_i && wb_stb_i;

  // Command write with no room left in the FIFO
  assign cmd_stall = wb_we_i && (wb_adr_i == REG_CMD) && instr.full;

  always_ff @(posedge clk) begin
    if (!n_rst) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (wb_req && !cmd_stall) begin
          next_state = ACK;
        end
      end
      ACK:  next_state = WAIT_RELEASE; // Ack lasts one cycle only
      WAIT_RELEASE: begin
        if (!wb_req) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  assign wb_ack_o = (state == ACK);
  assign wr_en    = wb_ack_o && wb_we_i;

  // Parameter registers load on the acked cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (wb_adr_i)
        REG_X1:    x1_q <= coord_x_t'(wb_dat_i);
        REG_Y1:    y1_q <= coord_y_t'(wb_dat_i);
        REG_X2:    x2_q <= coord_x_t'(wb_dat_i);
        REG_Y2:    y2_q <= coord_y_t'(wb_dat_i);
        REG_COLOR: color_q <= color_t'(wb_dat_i);
        default: ;
      endcase
    end
  end

  // Instruction leaves together with the command ack
  assign instr.push     = wr_en && (wb_adr_i == REG_CMD);
  assign instr.w_opcode = opcode_t'(wb_dat_i); // Low nibble
  assign instr.w_x1     = x1_q;
  assign instr.w_y1     = y1_q;
  assign instr.w_x2     = x2_q;
  assign instr.w_y2     = y2_q;
  assign instr.w_color  = color_q;

  always_comb begin
    status_word = '0;
    status_word[STAT_EMPTY_BIT] = instr.empty;
    status_word[STAT_FULL_BIT]  = instr.full;
    status_word[STAT_BUSY_BIT]  = engine_busy_i;
  end

  // Read mux, sampled by the master while ack is high
  always_comb begin
    case (wb_adr_i)
      REG_X1:     wb_dat_o = wb_data_t'(x1_q);
      REG_Y1:     wb_dat_o = wb_data_t'(y1_q);
      REG_X2:     wb_dat_o = wb_data_t'(x2_q);
      REG_Y2:     wb_dat_o = wb_data_t'(y2_q);
      REG_COLOR:  wb_dat_o = wb_data_t'(color_q);
      REG_STATUS: wb_dat_o = status_word;
      default:    wb_dat_o = '0; // Command register reads as zero
    endcase
  end

endmodule

/* source/gpu_instruction_fifo.sv */
`timescale 1ns/1ps

module gpu_instruction_fifo
  import gpu_geom_pkg::*, gpu_cmd_pkg::*;
  #(
  parameter int FIFO_DEPTH = 8 // Power of two, at least 2
  )
  (
  input  logic        clk,
  input  logic        n_rst,
  gpu_instr_if.buffer instr
  );

  localparam int PTR_W   = $clog2(FIFO_DEPTH);
  localparam int ENTRY_W = $bits(opcode_t) + 2 * $bits(coord_x_t)
                         + 2 * $bits(coord_y_t) + $bits(color_t);

  typedef logic [ENTRY_W-1:0] entry_t;

  entry_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;  // Extra bit so a full FIFO is distinct from empty

  logic do_push;
  logic do_pop;

  assign do_push = instr.push && !instr.full;
  assign do_pop  = instr.pop && !instr.empty;

  // Storage, written only on accepted pushes
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= {instr.w_opcode, instr.w_x1, instr.w_y1,
                      instr.w_x2, instr.w_y2, instr.w_color};
    end
  end

  // Head of the queue is always on the read side
  assign {instr.r_opcode, instr.r_x1, instr.r_y1,
          instr.r_x2, instr.r_y2, instr.r_color} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!n_rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps on its own at a power of two
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;               // Both or neither, occupancy holds
      endcase
    end
  end

  assign instr.empty = (count == '0);
  assign instr.full  = (count == (PTR_W + 1)'(FIFO_DEPTH));

endmodule

/* source/gpu_draw_engine.sv */
`timescale 1ns/1ps

module gpu_draw_engine
  import gpu_geom_pkg::*, gpu_cmd_pkg::*;
  #(
  parameter int SCREEN_W = 640,
  parameter int SCREEN_H = 480
  )
  (
  input  logic          clk,
  input  logic          n_rst,
  gpu_instr_if.consumer instr,
  output logic          busy_o,
  output logic          pixel_valid_o,
  input  logic          pixel_ready_i,
  output coord_x_t      pixel_x_o,
  output coord_y_t      pixel_y_o,
  output color_t        pixel_color_o
  );

  // LOAD shows the first pixel, or drops an undefined opcode
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    DRAW
  } state_t;

  state_t state;

  // Ordered box of the instruction at the FIFO head
  logic     op_draws;
  coord_x_t box_x_lo;
  coord_x_t box_x_hi;
  coord_y_t box_y_lo;
  coord_y_t box_y_hi;
  color_t   box_color;

  // Box of the instruction being walked
  coord_x_t x_lo_q;
  coord_x_t x_hi_q;
  coord_y_t y_hi_q;
  coord_x_t cur_x;
  coord_y_t cur_y;
  color_t   color_q;
  logic     draws_q;

  logic take;
  logic xfer;
  logic last_pixel;

  always_comb begin
    op_draws  = 1'b1;
    box_color = instr.r_color;
    box_x_lo  = (instr.r_x1 < instr.r_x2) ? instr.r_x1 : instr.r_x2;
    box_x_hi  = (instr.r_x1 < instr.r_x2) ? instr.r_x2 : instr.r_x1;
    box_y_lo  = (instr.r_y1 < instr.r_y2) ? instr.r_y1 : instr.r_y2;
    box_y_hi  = (instr.r_y1 < instr.r_y2) ? instr.r_y2 : instr.r_y1;
    case (instr.r_opcode)
      OP_POINT: begin
        box_x_lo = instr.r_x1;
        box_x_hi = instr.r_x1;
        box_y_lo = instr.r_y1;
        box_y_hi = instr.r_y1;
      end
      OP_HLINE: begin
        box_y_lo = instr.r_y1; // Single row
        box_y_hi = instr.r_y1;
      end
      OP_RECT: ;
      OP_CLEAR: begin
        box_x_lo = '0;
        box_x_hi = coord_x_t'(SCREEN_W - 1);
        box_y_lo = '0;
        box_y_hi = coord_y_t'(SCREEN_H - 1);
      end
      default: op_draws = 1'b0; // NOP and undefined codes
    endcase
  end

  assign take       = (state == IDLE) && !instr.empty;
  assign instr.pop  = take;
  assign busy_o     = (state != IDLE);

  assign pixel_valid_o = (state == DRAW) || ((state == LOAD) && draws_q);
  assign xfer          = pixel_valid_o && pixel_ready_i;
  assign last_pixel    = (cur_x == x_hi_q) && (cur_y == y_hi_q);

  always_ff @(posedge clk) begin
    if (!n_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (take) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          if (!draws_q) begin
            state <= IDLE;
          end else if (xfer) begin
            state <= last_pixel ? IDLE : DRAW;
          end
        end
        DRAW: begin
          if (xfer && last_pixel) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Walk x fastest, then y
  always_ff @(posedge clk) begin
    if (take) begin
      x_lo_q  <= box_x_lo;
      x_hi_q  <= box_x_hi;
      y_hi_q  <= box_y_hi;
      cur_x   <= box_x_lo;
      cur_y   <= box_y_lo;
      color_q <= box_color;
      draws_q <= op_draws;
    end else if (xfer && !last_pixel) begin
      if (cur_x == x_hi_q) begin
        cur_x <= x_lo_q; // Next row
        cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  // Held steady while ready is low
  assign pixel_x_o     = cur_x;
  assign pixel_y_o     = cur_y;
  assign pixel_color_o = color_q;

endmodule

/* source/gpu_cmd_top.sv */
`timescale 1ns/1ps

module gpu_cmd_top
  import gpu_geom_pkg::*, gpu_cmd_pkg::*;
  #(
  parameter int FIFO_DEPTH = 8,
  parameter int SCREEN_W   = 640,
  parameter int SCREEN_H   = 480
  )
  (
  input  logic     clk,
  input  logic     n_rst,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_addr_t wb_adr_i,
  input  wb_data_t wb_dat_i,
  output wb_data_t wb_dat_o,
  output logic     wb_ack_o,
  output logic     pixel_valid_o,
  input  logic     pixel_ready_i,
  output coord_x_t pixel_x_o,
  output coord_y_t pixel_y_o,
  output color_t   pixel_color_o
  );

  logic engine_busy;

  gpu_instr_if u_instr_if ();

  // Producer side, Wishbone registers
  gpu_wb_cmd_decoder u_decoder (
    .clk           (clk),
    .n_rst         (n_rst),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .engine_busy_i (engine_busy),
    .instr         (u_instr_if.producer)
  );

  gpu_instruction_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk   (clk),
    .n_rst (n_rst),
    .instr (u_instr_if.buffer)
  );

  // Consumer side, pixel stream out
  gpu_draw_engine #(
    .SCREEN_W (SCREEN_W),
    .SCREEN_H (SCREEN_H)
  ) u_engine (
    .clk           (clk),
    .n_rst         (n_rst),
    .instr         (u_instr_if.consumer),
    .busy_o        (engine_busy),
    .pixel_valid_o (pixel_valid_o),
    .pixel_ready_i (pixel_ready_i),
    .pixel_x_o     (pixel_x_o),
    .pixel_y_o     (pixel_y_o),
    .pixel_color_o (pixel_color_o)
  );

endmodule

/* testbench/tb_gpu_cmd.sv */
`timescale 1ns/1ps

module tb_gpu_cmd
  import gpu_geom_pkg::*, gpu_cmd_pkg::*;
  ();

  localparam int FIFO_DEPTH     = 4;
  localparam int SCREEN_W       = 8;
  localparam int SCREEN_H       = 4;
  localparam int TIMEOUT_CYCLES = 4000; // Longest sequence times three

  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    color_t   color;
  } pixel_t;

  logic     clk;
  logic     n_rst;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  wb_addr_t wb_adr_i;
  wb_data_t wb_dat_i;
  wb_data_t wb_dat_o;
  logic     wb_ack_o;
  logic     pixel_valid_o;
  logic     pixel_ready_i = 1'b0;
  coord_x_t pixel_x_o;
  coord_y_t pixel_y_o;
  color_t   pixel_color_o;

  pixel_t got_q[$];   // Pixels seen on the stream
  pixel_t exp_q[$];   // Pixels the model predicts
  logic   ready_random;
  logic   ready_level;
  integer seed;
  int     cycles;

  gpu_cmd_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .SCREEN_W   (SCREEN_W),
    .SCREEN_H   (SCREEN_H)
  ) u_dut (
    .clk           (clk),
    .n_rst         (n_rst),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .pixel_valid_o (pixel_valid_o),
    .pixel_ready_i (pixel_ready_i),
    .pixel_x_o     (pixel_x_o),
    .pixel_y_o     (pixel_y_o),
    .pixel_color_o (pixel_color_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the tests did not finish within %0d clock cycles", cycles);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped by the cycle limit");
      end
    end
  end

  // Sink readiness drops about one cycle in four when random
  always @(posedge clk) begin
    #1;
    if (ready_random) begin
      pixel_ready_i = (($random(seed) & 3) != 0);
    end else begin
      pixel_ready_i = ready_level;
    end
  end

  // Transfers are stable at the falling edge
  always @(negedge clk) begin
    if (n_rst && pixel_valid_o && pixel_ready_i) begin
      got_q.push_back({pixel_x_o, pixel_y_o, pixel_color_o});
    end
  end

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic compare_word(input wb_data_t got, input wb_data_t exp, input string what);
    if (got !== exp) begin
      report_error($sformatf("%s got %08h expected %08h", what, got, exp));
    end
  endtask

  task automatic compare_pixel(input string what, input int idx,
                               input coord_x_t got_x, input coord_y_t got_y,
                               input color_t got_c, input coord_x_t exp_x,
                               input coord_y_t exp_y, input color_t exp_c);
    if (got_x !== exp_x || got_y !== exp_y || got_c !== exp_c) begin
      report_error($sformatf("%s pixel %0d got (%0d,%0d,%06h) expected (%0d,%0d,%06h)",
                             what, idx, got_x, got_y, got_c, exp_x, exp_y, exp_c));
    end
  endtask

  // Raise the strobe one step after the edge
  task automatic wb_start(input wb_addr_t adr, input wb_data_t dat, input logic we);
    @(posedge clk);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
  endtask

  task automatic wb_finish(output wb_data_t rd);
    do begin
      @(negedge clk);
    end while (!wb_ack_o);
    rd = wb_dat_o;
    @(posedge clk);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    wb_start(adr, dat, 1'b1);
    wb_finish(unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t rd);
    wb_start(adr, '0, 1'b0);
    wb_finish(rd);
  endtask

  task automatic set_shape(input int x1, input int y1, input int x2, input int y2,
                           input int color);
    wb_write(REG_X1, wb_data_t'(x1));
    wb_write(REG_Y1, wb_data_t'(y1));
    wb_write(REG_X2, wb_data_t'(x2));
    wb_write(REG_Y2, wb_data_t'(y2));
    wb_write(REG_COLOR, wb_data_t'(color));
  endtask

  // Expected pixels walk the ordered box x fastest, then y
  task automatic model_cmd(input opcode_t op, input int x1, input int y1,
                           input int x2, input int y2, input int color);
    int     x_lo;
    int     x_hi;
    int     y_lo;
    int     y_hi;
    pixel_t p;
    x_lo = (x1 < x2) ? x1 : x2;
    x_hi = (x1 < x2) ? x2 : x1;
    y_lo = (y1 < y2) ? y1 : y2;
    y_hi = (y1 < y2) ? y2 : y1;
    case (op)
      OP_POINT: begin
        x_lo = x1;
        x_hi = x1;
        y_lo = y1;
        y_hi = y1;
      end
      OP_HLINE: begin
        y_lo = y1;
        y_hi = y1;
      end
      OP_RECT: ;
      OP_CLEAR: begin
        x_lo = 0;
        x_hi = SCREEN_W - 1;
        y_lo = 0;
        y_hi = SCREEN_H - 1;
      end
      default: return; // No pixels for NOP or unknown codes
    endcase
    for (int y = y_lo; y <= y_hi; y++) begin
      for (int x = x_lo; x <= x_hi; x++) begin
        p.x     = coord_x_t'(x);
        p.y     = coord_y_t'(y);
        p.color = color_t'(color);
        exp_q.push_back(p);
      end
    end
  endtask

  task automatic draw(input opcode_t op, input int x1, input int y1, input int x2,
                      input int y2, input int color);
    set_shape(x1, y1, x2, y2, color);
    model_cmd(op, x1, y1, x2, y2, color);
    wb_write(REG_CMD, wb_data_t'(op));
  endtask

  // Poll status until the FIFO is empty and the engine idle
  task automatic wait_idle();
    wb_data_t st;
    wb_read(REG_STATUS, st);
    while (!(st[STAT_EMPTY_BIT] && !st[STAT_BUSY_BIT])) begin
      wb_read(REG_STATUS, st);
    end
  endtask

  task automatic check_stream(input string what);
    pixel_t g;
    pixel_t e;
    int     n;
    wait_idle();
    if (got_q.size() != exp_q.size()) begin
      report_error($sformatf("%s produced %0d pixels, expected %0d",
                             what, got_q.size(), exp_q.size()));
    end
    n = 0;
    while (exp_q.size() > 0) begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      compare_pixel(what, n, g.x, g.y, g.color, e.x, e.y, e.color);
      n++;
    end
  endtask

  task automatic test_reset_state();
    wb_data_t st;
    repeat (4) begin
      @(negedge clk);
      if (pixel_valid_o || wb_ack_o) begin
        report_error("pixel valid or ack high with no bus activity after reset");
      end
    end
    wb_read(REG_STATUS, st);
    compare_word(st, 32'h1, "status after reset");
  endtask

  task automatic test_single_instr();
    draw(OP_POINT, 3, 2, 0, 0, 'h112233);
    check_stream("point");
    draw(OP_HLINE, 5, 1, 2, 3, 'h00ff80);
    check_stream("horizontal line");
    draw(opcode_t'(4'ha), 1, 1, 6, 3, 'h123456);
    draw(OP_NOP, 0, 0, 7, 3, 'h654321);
    check_stream("unknown opcode");
  endtask

  task automatic test_rect_swapped();
    draw(OP_RECT, 6, 3, 1, 1, 'hc0ffee);
    check_stream("rectangle");
  endtask

  task automatic test_clear();
    draw(OP_CLEAR, 5, 1, 2, 2, 'h0a0b0c);
    check_stream("clear");
  endtask

  task automatic test_backpressure();
    wb_data_t st;
    wb_data_t unused;
    ready_random = 1'b0;
    ready_level  = 1'b0;
    draw(OP_POINT, 0, 0, 0, 0, 'h000001); // Held in the engine
    draw(OP_HLINE, 1, 1, 3, 0, 'h000002);
    draw(OP_RECT, 4, 2, 5, 3, 'h000003);
    draw(OP_POINT, 7, 3, 0, 0, 'h000004);
    draw(OP_HLINE, 6, 0, 2, 0, 'h000005);
    wb_read(REG_STATUS, st);
    compare_word(st, 32'h6, "status with the FIFO full");
    set_shape(2, 2, 0, 0, 'h000006);
    model_cmd(OP_POINT, 2, 2, 0, 0, 'h000006);
    wb_start(REG_CMD, wb_data_t'(OP_POINT), 1'b1);
    repeat (20) begin
      @(negedge clk);
      if (wb_ack_o) begin
        report_error("command write was acked while the FIFO was full");
      end
    end
    ready_random = 1'b1;
    ready_level  = 1'b1;
    wb_finish(unused);
    check_stream("back-pressure");
  endtask

  task automatic test_interleave();
    wb_data_t st;
    draw(OP_CLEAR, 0, 0, 0, 0, 'h445566);
    draw(OP_RECT, 2, 1, 0, 0, 'h778899);
    draw(OP_POINT, 6, 2, 0, 0, 'habcdef);
    draw(OP_HLINE, 7, 3, 4, 0, 'h010203);
    check_stream("interleaved");
    wb_read(REG_STATUS, st);
    compare_word(st, 32'h1, "status after the stream ends");
  endtask

  initial begin
    n_rst        = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    ready_random = 1'b1;
    ready_level  = 1'b1;
    seed         = 32'h4dd0_2f85;
    repeat (3) @(posedge clk);
    #1;
    n_rst = 1'b1;

    test_reset_state();
    test_single_instr();
    test_rect_swapped();
    test_clear();
    test_backpressure();
    test_interleave();

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* tb.f */
source/gpu_geom_pkg.sv
source/gpu_cmd_pkg.sv
source/gpu_instr_if.sv
source/gpu_wb_cmd_decoder.sv
source/gpu_instruction_fifo.sv
source/gpu_draw_engine.sv
source/gpu_cmd_top.sv
testbench/tb_gpu_cmd.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GPU command front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_gpu_cmd -o tb_gpu_cmd_sim

# The simulator status is hidden by the pipe, the log decides
./obj_dir/tb_gpu_cmd_sim 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"
